//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sequencer
LINT_TOP  ?= sequencer_top
SEED      ?= 0
FILELIST  ?= sequencer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(LINT_TOP) \
		hw/seq_pkg.sv hw/seq_loop_if.sv hw/seq_instr_decode.sv \
		hw/seq_program_counter.sv hw/seq_addr_gen.sv hw/seq_ctrl_out.sv \
		hw/sequencer_top.sv

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/seq_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module seq_addr_gen #(
    parameter int ADDR_W     = seq_pkg::ADDR_W,
    parameter int STEP_W     = seq_pkg::STEP_W,
    parameter bit HAS_BACKUP = 1'b1
) (
    input  logic              CLK,
    input  logic              RSTL,
    input  logic              purge,
    input  seq_pkg::addr_op_e op,
    input  logic [STEP_W-1:0] step,
    output logic [ADDR_W-1:0] addr
);
    import seq_pkg::*;

    logic [ADDR_W-1:0] step_sx;
    logic [ADDR_W-1:0] step_zx;
    logic [ADDR_W-1:0] bak;
    logic              bak_vld;

    // Signed step, unsigned load value
    assign step_sx = {{(ADDR_W-STEP_W){step[STEP_W-1]}}, step};
    assign step_zx = {{(ADDR_W-STEP_W){1'b0}}, step};

    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
            addr <= '0;
        else if (purge)
            addr <= '0;
        else
        begin
            case (op)
                AOP_STEP: addr <= addr + step_sx;
                AOP_LOAD: addr <= step_zx;
                AOP_MARK: addr <= bak_vld ? bak : addr + step_sx;
                default:  addr <= addr;
            endcase
        end
    end

    if (HAS_BACKUP)
    begin : g_bak
        // Mark toggles between save and restore
        always_ff @(posedge CLK or negedge RSTL)
        begin
            if (!RSTL)
                bak_vld <= 1'b0;
            else if (purge)
                bak_vld <= 1'b0;
            else if (op == AOP_MARK)
                bak_vld <= ~bak_vld;
        end

        always_ff @(posedge CLK)
        begin
            if ((op == AOP_MARK) && !bak_vld)
                bak <= addr;
        end
    end
    else
    begin : g_no_bak
        assign bak     = '0;
        assign bak_vld = 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/seq_ctrl_out.sv
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl_out #(
    parameter int ADDR_W = seq_pkg::ADDR_W,
    parameter int CTRL_W = seq_pkg::CTRL_W
) (
    input  logic              CLK,
    input  logic              RSTL,
    input  logic              purge,
    input  logic [ADDR_W-1:0] raddr_x_d,
    input  logic [ADDR_W-1:0] waddr_x_d,
    input  logic [ADDR_W-1:0] raddr_w_d,
    input  logic [CTRL_W-1:0] ctrl_d,
    output logic [ADDR_W-1:0] raddr_x,
    output logic [ADDR_W-1:0] waddr_x,
    output logic [ADDR_W-1:0] raddr_w,
    output logic              bank_x,
    output logic              bank_w,
    output logic              rceb_x,
    output logic              wceb_x,
    output logic              req_w,
    output logic              mac_en,
    output logic              nl_en,
    output logic              seq_fin
);
    import seq_pkg::*;

    logic [CTRL_W-1:0] ctrl_q;

    // One cycle behind the fetch, frozen during purge
    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
        begin
            raddr_x <= '0;
            waddr_x <= '0;
            raddr_w <= '0;
            ctrl_q  <= CTRL_W'(CTRL_IDLE);
        end
        else if (!purge)
        begin
            raddr_x <= raddr_x_d;
            waddr_x <= waddr_x_d;
            raddr_w <= raddr_w_d;
            ctrl_q  <= ctrl_d;
        end
    end

    assign bank_x  = ctrl_q[CTRL_BANK_X];
    assign bank_w  = ctrl_q[CTRL_BANK_W];
    assign rceb_x  = ctrl_q[CTRL_RCEB_X];
    assign wceb_x  = ctrl_q[CTRL_WCEB_X];
    assign req_w   = ctrl_q[CTRL_REQ_W];
    assign mac_en  = ctrl_q[CTRL_MAC_EN];
    assign nl_en   = ctrl_q[CTRL_NL_EN];
    assign seq_fin = ctrl_q[CTRL_SEQ_FIN];

endmodule

`default_nettype wire

//--- hw/seq_instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module seq_instr_decode #(
    parameter int PC_W    = seq_pkg::PC_W,
    parameter int LOOP_W  = seq_pkg::LOOP_W,
    parameter int STEP_W  = seq_pkg::STEP_W,
    parameter int CTRL_W  = seq_pkg::CTRL_W,
    parameter int INSTR_W = seq_pkg::INSTR_W
) (
    input  logic [INSTR_W-1:0] instr_data,
    input  logic               busy_w,
    input  logic               busy_xi,
    input  logic               busy_xo,
    seq_loop_if.decoder        loop,
    output seq_pkg::addr_op_e  op_rx,
    output seq_pkg::addr_op_e  op_wx,
    output seq_pkg::addr_op_e  op_rw,
    output logic [STEP_W-1:0]  step_rx,
    output logic [STEP_W-1:0]  step_wx,
    output logic [STEP_W-1:0]  step_rw,
    output logic [CTRL_W-1:0]  ctrl
);
    import seq_pkg::*;

    wait_sel_e wait_sel;
    logic      stall;

    assign wait_sel = wait_sel_e'(instr_data[F_WAIT_SEL +: SEL_W]);

    always_comb
    begin
        case (wait_sel)
            WAIT_W:  stall = busy_w;
            WAIT_XI: stall = busy_xi;
            WAIT_XO: stall = busy_xo;
            default: stall = 1'b0;
        endcase
    end

    // Loop and jump control, no updates while stalled
    assign loop.stall        = stall;
    assign loop.jump_en      = instr_data[F_JUMP_EN] & ~stall;
    assign loop.jump_sel     = instr_data[F_JUMP_SEL +: SEL_W];
    assign loop.jump_target  = instr_data[F_JUMP_TGT +: PC_W];
    assign loop.cnt_load_en  = instr_data[F_CNT_LD_EN] & ~stall;
    assign loop.cnt_load_sel = instr_data[F_CNT_LD_SEL +: SEL_W];
    assign loop.cnt_load_val = instr_data[F_CNT_LD_VAL +: LOOP_W];

    assign op_rx = stall ? AOP_HOLD : addr_op_e'(instr_data[F_RX_OP +: OP_W]);
    assign op_wx = stall ? AOP_HOLD : addr_op_e'(instr_data[F_WX_OP +: OP_W]);
    assign op_rw = stall ? AOP_HOLD : addr_op_e'(instr_data[F_RW_OP +: OP_W]);

    assign step_rx = instr_data[F_RX_STEP +: STEP_W];
    assign step_wx = instr_data[F_WX_STEP +: STEP_W];
    assign step_rw = instr_data[F_RW_STEP +: STEP_W];

    // Control bits pass through even while stalled
    assign ctrl = instr_data[F_CTRL +: CTRL_W];

endmodule

`default_nettype wire

//--- hw/seq_loop_if.sv
`timescale 1ns/1ps
`default_nettype none

interface seq_loop_if #(
    parameter int PC_W   = seq_pkg::PC_W,
    parameter int LOOP_W = seq_pkg::LOOP_W
);
    import seq_pkg::*;

    logic              stall;
    logic              jump_en;
    logic [SEL_W-1:0]  jump_sel;
    logic [PC_W-1:0]   jump_target;
    logic              cnt_load_en;
    logic [SEL_W-1:0]  cnt_load_sel;
    logic [LOOP_W-1:0] cnt_load_val;

    modport decoder (output stall, jump_en, jump_sel, jump_target,
                     cnt_load_en, cnt_load_sel, cnt_load_val);

    modport pc (input stall, jump_en, jump_sel, jump_target,
                cnt_load_en, cnt_load_sel, cnt_load_val);

endinterface

`default_nettype wire

//--- hw/seq_pkg.sv
`default_nettype none

package seq_pkg;

    // Default sizes
    localparam int PC_W      = 8;
    localparam int ADDR_W    = 16;
    localparam int LOOP_W    = 8;
    localparam int NUM_LOOPS = 4;
    localparam int STEP_W    = 8;
    localparam int CTRL_W    = 8;
    localparam int INSTR_W   = 64;

    // Select and op field widths
    localparam int SEL_W = 2;
    localparam int OP_W  = 2;

    // Instruction fields, low bit of each
    localparam int F_WAIT_SEL   = 0;
    localparam int F_JUMP_EN    = F_WAIT_SEL + SEL_W;
    localparam int F_JUMP_SEL   = F_JUMP_EN + 1;
    localparam int F_JUMP_TGT   = F_JUMP_SEL + SEL_W;
    localparam int F_CNT_LD_EN  = F_JUMP_TGT + PC_W;
    localparam int F_CNT_LD_SEL = F_CNT_LD_EN + 1;
    localparam int F_CNT_LD_VAL = F_CNT_LD_SEL + SEL_W;
    localparam int F_RX_OP      = F_CNT_LD_VAL + LOOP_W;
    localparam int F_RX_STEP    = F_RX_OP + OP_W;
    localparam int F_WX_OP      = F_RX_STEP + STEP_W;
    localparam int F_WX_STEP    = F_WX_OP + OP_W;
    localparam int F_RW_OP      = F_WX_STEP + STEP_W;
    localparam int F_RW_STEP    = F_RW_OP + OP_W;
    localparam int F_CTRL       = F_RW_STEP + STEP_W;
    // Bits 62 and 63 spare

    // Control bits within the ctrl field
    localparam int CTRL_BANK_X  = 0;
    localparam int CTRL_BANK_W  = 1;
    localparam int CTRL_RCEB_X  = 2;
    localparam int CTRL_WCEB_X  = 3;
    localparam int CTRL_REQ_W   = 4;
    localparam int CTRL_MAC_EN  = 5;
    localparam int CTRL_NL_EN   = 6;
    localparam int CTRL_SEQ_FIN = 7;

    // Active-low chip enables off, everything else low
    localparam logic [CTRL_W-1:0] CTRL_IDLE =
        CTRL_W'((1 << CTRL_RCEB_X) | (1 << CTRL_WCEB_X));

    // Busy input that stalls the instruction
    typedef enum logic [SEL_W-1:0] {
        WAIT_NONE,
        WAIT_W,
        WAIT_XI,
        WAIT_XO
    } wait_sel_e;

    // Per address generator operation
    typedef enum logic [OP_W-1:0] {
        AOP_HOLD = 2'd0,
        AOP_STEP,
        AOP_LOAD,
        AOP_MARK
    } addr_op_e;

endpackage

`default_nettype wire

//--- hw/seq_program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module seq_program_counter #(
    parameter int PC_W      = seq_pkg::PC_W,
    parameter int LOOP_W    = seq_pkg::LOOP_W,
    parameter int NUM_LOOPS = seq_pkg::NUM_LOOPS
) (
    input  logic            CLK,
    input  logic            RSTL,
    input  logic            purge,
    seq_loop_if.pc          loop,
    output logic [PC_W-1:0] pc
);

    logic [LOOP_W-1:0] cnt [NUM_LOOPS];
    logic [LOOP_W-1:0] jump_cnt;
    logic              take_jump;

    // Counter selected by the jump
    assign jump_cnt = cnt[loop.jump_sel];

    // Last pass of the loop falls through
    assign take_jump = loop.jump_en && (jump_cnt != LOOP_W'(1));

    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
        begin
            pc <= '0;
        end
        else if (purge)
        begin
            pc <= '0;
        end
        else if (!loop.stall)
        begin
            if (take_jump)
                pc <= loop.jump_target;
            else
                pc <= pc + 1'b1;
        end
    end

    for (genvar i = 0; i < NUM_LOOPS; i++)
    begin : g_cnt
        logic load_hit;
        logic jump_hit;

        assign load_hit = loop.cnt_load_en && (loop.cnt_load_sel == i);
        assign jump_hit = loop.jump_en && (loop.jump_sel == i);

        always_ff @(posedge CLK or negedge RSTL)
        begin
            if (!RSTL)
            begin
                cnt[i] <= '0;
            end
            else if (purge)
            begin
                cnt[i] <= '0;
            end
            else if (load_hit && (cnt[i] == '0))
            begin
                // Only an empty counter takes a new value
                cnt[i] <= loop.cnt_load_val;
            end
            else if (jump_hit)
            begin
                cnt[i] <= cnt[i] - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/sequencer_top.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer_top #(
    parameter int PC_W      = seq_pkg::PC_W,
    parameter int ADDR_W    = seq_pkg::ADDR_W,
    parameter int LOOP_W    = seq_pkg::LOOP_W,
    parameter int NUM_LOOPS = seq_pkg::NUM_LOOPS,
    parameter int STEP_W    = seq_pkg::STEP_W,
    parameter int CTRL_W    = seq_pkg::CTRL_W,
    parameter int INSTR_W   = seq_pkg::INSTR_W
) (
    input  logic               CLK,
    input  logic               RSTL,
    input  logic               purge,
    input  logic               busy_w,
    input  logic               busy_xi,
    input  logic               busy_xo,
    input  logic [INSTR_W-1:0] instr_data,
    output logic [PC_W-1:0]    instr_addr,
    output logic [ADDR_W-1:0]  raddr_x,
    output logic [ADDR_W-1:0]  waddr_x,
    output logic [ADDR_W-1:0]  raddr_w,
    output logic               bank_x,
    output logic               bank_w,
    output logic               rceb_x,
    output logic               wceb_x,
    output logic               req_w,
    output logic               mac_en,
    output logic               nl_en,
    output logic               seq_fin
);
    import seq_pkg::*;

    addr_op_e          op_rx;
    addr_op_e          op_wx;
    addr_op_e          op_rw;
    logic [STEP_W-1:0] step_rx;
    logic [STEP_W-1:0] step_wx;
    logic [STEP_W-1:0] step_rw;
    logic [CTRL_W-1:0] ctrl;
    logic [ADDR_W-1:0] cur_raddr_x;
    logic [ADDR_W-1:0] cur_waddr_x;
    logic [ADDR_W-1:0] cur_raddr_w;

    seq_loop_if #(.PC_W(PC_W), .LOOP_W(LOOP_W)) loop_if ();

    seq_instr_decode #(.PC_W(PC_W), .LOOP_W(LOOP_W), .STEP_W(STEP_W),
                       .CTRL_W(CTRL_W), .INSTR_W(INSTR_W)) seq_instr_decode_i (
        .instr_data(instr_data), .busy_w(busy_w), .busy_xi(busy_xi), .busy_xo(busy_xo),
        .loop(loop_if.decoder), .op_rx(op_rx), .op_wx(op_wx), .op_rw(op_rw),
        .step_rx(step_rx), .step_wx(step_wx), .step_rw(step_rw), .ctrl(ctrl));

    // Program counter goes straight out as the fetch address
    seq_program_counter #(.PC_W(PC_W), .LOOP_W(LOOP_W), .NUM_LOOPS(NUM_LOOPS))
    seq_program_counter_i (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .loop(loop_if.pc), .pc(instr_addr));

    seq_addr_gen #(.ADDR_W(ADDR_W), .STEP_W(STEP_W), .HAS_BACKUP(1'b1)) raddr_x_gen_i (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .op(op_rx), .step(step_rx), .addr(cur_raddr_x));

    // Write address has no backup, mark steps
    seq_addr_gen #(.ADDR_W(ADDR_W), .STEP_W(STEP_W), .HAS_BACKUP(1'b0)) waddr_x_gen_i (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .op(op_wx), .step(step_wx), .addr(cur_waddr_x));

    seq_addr_gen #(.ADDR_W(ADDR_W), .STEP_W(STEP_W), .HAS_BACKUP(1'b1)) raddr_w_gen_i (
        .CLK(CLK), .RSTL(RSTL), .purge(purge), .op(op_rw), .step(step_rw), .addr(cur_raddr_w));

    seq_ctrl_out #(.ADDR_W(ADDR_W), .CTRL_W(CTRL_W)) seq_ctrl_out_i (
        .CLK(CLK), .RSTL(RSTL), .purge(purge),
        .raddr_x_d(cur_raddr_x), .waddr_x_d(cur_waddr_x), .raddr_w_d(cur_raddr_w),
        .ctrl_d(ctrl), .raddr_x(raddr_x), .waddr_x(waddr_x), .raddr_w(raddr_w),
        .bank_x(bank_x), .bank_w(bank_w), .rceb_x(rceb_x), .wceb_x(wceb_x),
        .req_w(req_w), .mac_en(mac_en), .nl_en(nl_en), .seq_fin(seq_fin));

endmodule

`default_nettype wire

//--- sequencer.f
hw/seq_pkg.sv
hw/seq_loop_if.sv
hw/seq_instr_decode.sv
hw/seq_program_counter.sv
hw/seq_addr_gen.sv
hw/seq_ctrl_out.sv
hw/sequencer_top.sv
tests/sequencer_asserts.sv
tests/tb_sequencer.sv

//--- tests/sequencer_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer_asserts #(
    parameter int PC_W   = seq_pkg::PC_W,
    parameter int ADDR_W = seq_pkg::ADDR_W,
    parameter int CTRL_W = seq_pkg::CTRL_W
) (
    input wire logic              CLK,
    input wire logic              RSTL,
    input wire logic              purge,
    input wire logic              stall,
    input wire logic [PC_W-1:0]   pc,
    input wire logic [ADDR_W-1:0] raddr_x,
    input wire logic [ADDR_W-1:0] waddr_x,
    input wire logic [ADDR_W-1:0] raddr_w,
    input wire logic [CTRL_W-1:0] ctrl
);
    import seq_pkg::*;

    int fail_count = 0;

    pc_holds_on_stall: assert property (@(posedge CLK) disable iff (!RSTL)
        (stall && !purge) |=> $stable(pc))
        else
        begin
            $error("pc moved while stalled");
            fail_count++;
        end

    pc_zero_after_purge: assert property (@(posedge CLK) disable iff (!RSTL)
        purge |=> (pc == '0))
        else
        begin
            $error("pc not zero after purge");
            fail_count++;
        end

    outputs_hold_on_purge: assert property (@(posedge CLK) disable iff (!RSTL)
        purge |=> ($stable(ctrl) && $stable(raddr_x) && $stable(waddr_x) && $stable(raddr_w)))
        else
        begin
            $error("outputs changed during purge");
            fail_count++;
        end

    // First edge out of reset
    idle_after_reset: assert property (@(posedge CLK)
        $rose(RSTL) |-> (ctrl == CTRL_IDLE && raddr_x == '0 && waddr_x == '0
                         && raddr_w == '0))
        else
        begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule

bind sequencer_top sequencer_asserts sequencer_asserts_i (
    .CLK(CLK), .RSTL(RSTL), .purge(purge), .stall(loop_if.stall), .pc(instr_addr),
    .raddr_x(raddr_x), .waddr_x(waddr_x), .raddr_w(raddr_w),
    .ctrl({seq_fin, nl_en, mac_en, req_w, wceb_x, rceb_x, bank_w, bank_x}));

`default_nettype wire

//--- tests/tb_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sequencer;
    import seq_pkg::*;

    // Run length of each test in cycles
    localparam int RESET_CYCLES     = 5;
    localparam int PURGE_CYCLES     = 3;
    localparam int STRAIGHT_CYCLES  = 12;
    localparam int LOOP_CYCLES      = 12;
    localparam int NESTED_CYCLES    = 24;
    localparam int ADDR_CYCLES      = 10;
    localparam int BUSY_CYCLES      = 30;
    localparam int PURGE_RUN_CYCLES = 5;
    localparam int RESTART_CYCLES   = 8;
    localparam int TEST_CYCLES      = RESET_CYCLES + 1 + 7 * PURGE_CYCLES + STRAIGHT_CYCLES
        + LOOP_CYCLES + NESTED_CYCLES + ADDR_CYCLES + BUSY_CYCLES + PURGE_RUN_CYCLES
        + RESTART_CYCLES;
    localparam int WATCHDOG_CYCLES  = 2 * TEST_CYCLES;

    logic CLK, RSTL, purge, busy_w, busy_xi, busy_xo, rand_busy;
    logic [INSTR_W-1:0] instr_data;
    logic [PC_W-1:0] instr_addr;
    logic [ADDR_W-1:0] raddr_x, waddr_x, raddr_w;
    logic bank_x, bank_w, rceb_x, wceb_x, req_w, mac_en, nl_en, seq_fin;
    logic [CTRL_W-1:0] ctrl_out;
    logic [INSTR_W-1:0] mem [2**PC_W];
    // Next program, copied into the memory while purge is high
    logic [INSTR_W-1:0] prog [2**PC_W];

    // Reference model state, advanced at each falling edge
    logic [PC_W-1:0] m_pc;
    logic [LOOP_W-1:0] m_cnt [NUM_LOOPS];
    logic [ADDR_W-1:0] m_addr [3], m_bak [3], o_addr [3];
    logic m_vld [3];
    logic [CTRL_W-1:0] o_ctrl;
    int errors = 0, tests = 0, failed = 0, fin_count = 0, seed = 32'hfe68_d231;

    sequencer_top sequencer_top_i (.*);

    assign ctrl_out = {seq_fin, nl_en, mac_en, req_w, wceb_x, rceb_x, bank_w, bank_x};
    always_comb instr_data = mem[instr_addr];

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        if (rand_busy)
            {busy_xo, busy_xi, busy_w} <= 3'($random(seed));
        else
            {busy_xo, busy_xi, busy_w} <= 3'b000;
    end

    function automatic logic [INSTR_W-1:0] ins_ctrl(input logic [CTRL_W-1:0] c);
        return INSTR_W'(c) << F_CTRL;
    endfunction

    function automatic logic [INSTR_W-1:0] ins_jump(input int sel, input int tgt);
        return (INSTR_W'(1) << F_JUMP_EN) | (INSTR_W'(sel) << F_JUMP_SEL)
             | (INSTR_W'(tgt) << F_JUMP_TGT);
    endfunction

    function automatic logic [INSTR_W-1:0] ins_load(input int sel, input int val);
        return (INSTR_W'(1) << F_CNT_LD_EN) | (INSTR_W'(sel) << F_CNT_LD_SEL)
             | (INSTR_W'(val) << F_CNT_LD_VAL);
    endfunction

    // Generator k: 0 raddr_x, 1 waddr_x, 2 raddr_w
    function automatic int op_pos(input int k);
        return (k == 0) ? F_RX_OP : (k == 1) ? F_WX_OP : F_RW_OP;
    endfunction

    function automatic logic [INSTR_W-1:0] ins_addr(input int k, input int op, input int st);
        return (INSTR_W'(op) << op_pos(k)) | (INSTR_W'(st & 8'hff) << (op_pos(k) + OP_W));
    endfunction

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic model_step();
        logic [INSTR_W-1:0] ins;
        logic [1:0] wsel, jsel, lsel, op;
        logic [STEP_W-1:0] st;
        logic stall;
        ins = mem[m_pc];
        wsel = ins[F_WAIT_SEL +: 2];
        jsel = ins[F_JUMP_SEL +: 2];
        lsel = ins[F_CNT_LD_SEL +: 2];
        stall = (wsel == 1 && busy_w) || (wsel == 2 && busy_xi) || (wsel == 3 && busy_xo);
        if (purge)
        begin
            m_pc = '0;
            for (int i = 0; i < NUM_LOOPS; i++)
                m_cnt[i] = '0;
            for (int k = 0; k < 3; k++)
            begin
                m_addr[k] = '0;
                m_vld[k] = 1'b0;
            end
        end
        else
        begin
            o_addr = m_addr;
            o_ctrl = ins[F_CTRL +: CTRL_W];
            if (!stall)
            begin
                if (ins[F_JUMP_EN] && m_cnt[jsel] != 1)
                    m_pc = ins[F_JUMP_TGT +: PC_W];
                else
                    m_pc = m_pc + 1'b1;
                for (int i = 0; i < NUM_LOOPS; i++)
                begin
                    if (ins[F_CNT_LD_EN] && lsel == i && m_cnt[i] == 0)
                        m_cnt[i] = ins[F_CNT_LD_VAL +: LOOP_W];
                    else if (ins[F_JUMP_EN] && jsel == i)
                        m_cnt[i] = m_cnt[i] - 1'b1;
                end
                for (int k = 0; k < 3; k++)
                begin
                    op = ins[op_pos(k) +: 2];
                    st = ins[op_pos(k) + OP_W +: STEP_W];
                    if (op == 1)
                        m_addr[k] = m_addr[k] + ADDR_W'($signed(st));
                    else if (op == 2)
                        m_addr[k] = ADDR_W'(st);
                    else if (op == 3 && k != 1 && m_vld[k])
                    begin
                        m_addr[k] = m_bak[k];
                        m_vld[k] = 1'b0;
                    end
                    else if (op == 3)
                    begin
                        // Save on the first mark, except the write address
                        if (k != 1)
                        begin
                            m_bak[k] = m_addr[k];
                            m_vld[k] = 1'b1;
                        end
                        m_addr[k] = m_addr[k] + ADDR_W'($signed(st));
                    end
                end
            end
        end
    endtask

    always @(negedge CLK)
    begin
        if (!RSTL)
        begin
            m_pc = '0;
            o_ctrl = CTRL_IDLE;
            for (int i = 0; i < NUM_LOOPS; i++)
                m_cnt[i] = '0;
            for (int k = 0; k < 3; k++)
            begin
                m_addr[k] = '0;
                o_addr[k] = '0;
                m_vld[k] = 1'b0;
            end
        end
        else
        begin
            assert (instr_addr == m_pc) else report("instr_addr", 32'(instr_addr), 32'(m_pc));
            assert (ctrl_out == o_ctrl) else report("ctrl", 32'(ctrl_out), 32'(o_ctrl));
            assert (raddr_x == o_addr[0]) else report("raddr_x", 32'(raddr_x), 32'(o_addr[0]));
            assert (waddr_x == o_addr[1]) else report("waddr_x", 32'(waddr_x), 32'(o_addr[1]));
            assert (raddr_w == o_addr[2]) else report("raddr_w", 32'(raddr_w), 32'(o_addr[2]));
            if (seq_fin)
                fin_count++;
            model_step();
        end
    end

    task automatic clear_prog();
        for (int a = 0; a < 2**PC_W; a++)
            prog[a] = '0;
    endtask

    task automatic pulse_purge();
        @(posedge CLK);
        purge <= 1'b1;
        // New program goes in while the sequencer ignores its instruction
        @(negedge CLK);
        mem = prog;
        @(posedge CLK);
        purge <= 1'b0;
        @(posedge CLK);
        fin_count = 0;
    endtask

    task automatic finish_test(input string name, input int base);
        tests++;
        if (errors != base)
            failed++;
        $display("%-10s %s (%0d errors)", name, (errors == base) ? "ok" : "FAIL", errors - base);
    endtask

    task automatic check_fins(input int exp);
        assert (fin_count == exp) else report("seq_fin pulses", 32'(fin_count), 32'(exp));
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * 8);
        $display("Timeout: the test run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        int base;
        int assert_fails;
        RSTL = 1'b0;
        purge = 1'b0;
        rand_busy = 1'b0;
        {busy_xo, busy_xi, busy_w} = 3'b000;
        clear_prog();
        mem = prog;
        repeat (RESET_CYCLES) @(posedge CLK);
        RSTL <= 1'b1;

        base = errors;
        @(negedge CLK);
        assert (instr_addr == '0 && ctrl_out == CTRL_IDLE && raddr_x == '0
                && waddr_x == '0 && raddr_w == '0)
            else report("reset outputs", 32'(ctrl_out), 32'(CTRL_IDLE));
        finish_test("reset", base);

        base = errors;
        for (int a = 0; a < 12; a++)
            prog[a] = ins_ctrl(CTRL_W'(a * 37 + 5));
        pulse_purge();
        repeat (STRAIGHT_CYCLES) @(posedge CLK);
        finish_test("straight", base);

        base = errors;
        clear_prog();
        prog[0] = ins_load(0, 3);
        prog[1] = ins_ctrl(8'h80);
        prog[2] = ins_jump(0, 1);
        prog[3] = ins_jump(3, 3);
        pulse_purge();
        repeat (LOOP_CYCLES) @(posedge CLK);
        check_fins(3);
        finish_test("loop", base);

        base = errors;
        prog[0] = ins_load(1, 2);
        prog[1] = ins_load(0, 3);
        prog[2] = ins_ctrl(8'h80);
        prog[3] = ins_jump(0, 2);
        prog[4] = ins_jump(1, 1);
        prog[5] = ins_jump(3, 5);
        pulse_purge();
        repeat (NESTED_CYCLES) @(posedge CLK);
        check_fins(6);
        finish_test("nested", base);

        base = errors;
        clear_prog();
        prog[0] = ins_addr(0, 1, 5) | ins_addr(2, 2, 8'h40) | ins_addr(1, 3, 3);
        prog[1] = ins_addr(0, 3, 2) | ins_addr(2, 1, -4);
        prog[2] = ins_addr(0, 1, -1) | ins_addr(2, 3, 1);
        prog[3] = ins_addr(0, 3, 0) | ins_addr(2, 3, 0) | ins_addr(1, 3, 3);
        prog[4] = ins_addr(0, 2, 8'hff) | ins_addr(1, 1, 8'h80);
        prog[5] = ins_jump(3, 5);
        pulse_purge();
        repeat (ADDR_CYCLES) @(posedge CLK);
        finish_test("addresses", base);

        base = errors;
        for (int a = 0; a < 12; a++)
            prog[a] = INSTR_W'(a % 4) | ins_addr(0, 1, 1) | ins_ctrl(CTRL_W'(a));
        pulse_purge();
        rand_busy <= 1'b1;
        repeat (BUSY_CYCLES) @(posedge CLK);
        rand_busy <= 1'b0;
        finish_test("busy", base);

        base = errors;
        for (int a = 0; a < 16; a++)
            prog[a] = ins_addr(0, 1, 2) | ins_addr(1, 1, 1) | ins_ctrl(CTRL_W'(a + 1));
        pulse_purge();
        repeat (PURGE_RUN_CYCLES) @(posedge CLK);
        pulse_purge();
        repeat (RESTART_CYCLES) @(posedge CLK);
        finish_test("purge", base);

        assert_fails = sequencer_top_i.sequencer_asserts_i.fail_count;
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests, failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
